// File: addr_map_pkg.sv
`default_nettype none

`include "mem_subsys_defines.svh"

package addr_map_pkg;

    // decoded target of a 16-bit address.
    typedef enum logic [2:0] {
        DRAM,
        LED,
        UART_STATUS,
        UART_DATA,
        UNMAPPED
    } region_t;

    typedef struct packed {
        logic [`WORD_WIDTH-`IO_OFS_WIDTH-1:0] page;   // must equal IO_PAGE for registers.
        logic [`IO_OFS_WIDTH-1:0]             offset; // register select in the io page.
    } io_fields_t;

    // the same word seen as a dram word address or as page plus offset.
    typedef union packed {
        logic [`WORD_WIDTH-1:0] raw;
        io_fields_t             io;
    } addr_word_t;

endpackage

`default_nettype wire

// File: dram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module dram_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        dram_req,
    input  wire periph_pkg::dram_op_t        dram_op,
    input  wire logic [`DRAM_ADDR_WIDTH-1:0] dram_addr,
    input  wire logic [`WORD_WIDTH-1:0]      dram_wdata,
    output logic                             dram_ack,
    output logic [`WORD_WIDTH-1:0]           dram_rdata
);

    localparam int TIMER_W = $clog2(`DRAM_REFRESH_PERIOD);
    localparam int LEFT_W  = $clog2(`DRAM_REFRESH_CYCLES + 1);
    localparam int LAT_W   = $clog2(`DRAM_LATENCY + 1);

    logic [`WORD_WIDTH-1:0] mem [0:`DRAM_LAST];
    logic [TIMER_W-1:0]     ref_timer;
    logic [LEFT_W-1:0]      ref_left;
    logic                   refreshing;
    logic                   busy;
    logic [LAT_W-1:0]       lat_cnt;
    logic                   finish;
    logic [`WORD_WIDTH-1:0] word_addr;

    assign word_addr  = dram_addr[`WORD_WIDTH-1:0];
    assign refreshing = (ref_left != '0);
    assign finish     = rst && busy && !refreshing && lat_cnt == LAT_W'(`DRAM_LATENCY - 1);

    initial begin
        for (int i = 0; i <= `DRAM_LAST; i++) begin
            mem[i] = '0;
        end
    end

    // each wrap of the free-running timer opens a refresh window.
    always_ff @(posedge clk) begin
        if (!rst) begin
            ref_timer <= '0;
            ref_left  <= '0;
        end else if (ref_timer == TIMER_W'(`DRAM_REFRESH_PERIOD - 1)) begin
            ref_timer <= '0;
            ref_left  <= LEFT_W'(`DRAM_REFRESH_CYCLES);
        end else begin
            ref_timer <= ref_timer + 1'b1;
            if (refreshing)
                ref_left <= ref_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy     <= 1'b0;
            dram_ack <= 1'b0;
            lat_cnt  <= '0;
        end else if (dram_ack) begin
            if (!dram_req)
                dram_ack <= 1'b0;
        end else if (busy) begin
            if (finish) begin
                busy     <= 1'b0;
                dram_ack <= 1'b1;
            end else if (!refreshing) begin
                lat_cnt <= lat_cnt + 1'b1; // latency is frozen during refresh.
            end
        end else if (dram_req && !refreshing) begin
            busy    <= 1'b1;
            lat_cnt <= LAT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            dram_rdata <= mem[word_addr];
            if (dram_op == periph_pkg::WRITE)
                mem[word_addr] <= dram_wdata;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        dram_req && $past(dram_req) |-> $stable(dram_addr))
        else $error("dram_addr changed while dram_req high");

    a_addr_zero_fill: assert property (@(posedge clk) disable iff (!rst)
        dram_req |-> dram_addr[`DRAM_ADDR_WIDTH-1:`WORD_WIDTH] == '0)
        else $error("dram_addr upper bits not zero");

endmodule

`default_nettype wire

// File: mem_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_map (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [`WORD_WIDTH-1:0]      pc,
    input  wire logic                        cpu_ready,
    input  wire logic [`WORD_WIDTH-1:0]      data_addr,
    input  wire logic [`WORD_WIDTH-1:0]      data_in,
    input  wire logic                        write_en,
    input  wire logic                        dram_ack,
    input  wire logic [`WORD_WIDTH-1:0]      dram_rdata,
    input  wire logic                        fifo_full,
    output logic [`WORD_WIDTH-1:0]           instr,
    output logic [`WORD_WIDTH-1:0]           read_data,
    output logic                             step_done,
    output logic [`LED_COUNT-1:0]            led,
    output logic                             dram_req,
    output periph_pkg::dram_op_t             dram_op,
    output logic [`DRAM_ADDR_WIDTH-1:0]      dram_addr,
    output logic [`WORD_WIDTH-1:0]           dram_wdata,
    output logic                             fifo_push,
    output logic [7:0]                       fifo_byte
);

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_FETCH_REQ = 3'd1;
    localparam logic [2:0] ST_FETCH_REL = 3'd2;
    localparam logic [2:0] ST_DATA_DEC  = 3'd3;
    localparam logic [2:0] ST_DATA_REQ  = 3'd4;
    localparam logic [2:0] ST_DATA_REL  = 3'd5;
    localparam logic [2:0] ST_DONE      = 3'd6;

    logic [2:0]               state;
    logic [`WORD_WIDTH-1:0]   last_pc;
    logic                     last_valid;
    logic [`WORD_WIDTH-1:0]   instr_buf;
    logic [`WORD_WIDTH-1:0]   data_buf;
    logic [`WORD_WIDTH-1:0]   fetch_addr;
    logic [`WORD_WIDTH-1:0]   io_rdata;
    addr_map_pkg::addr_word_t pc_word;
    addr_map_pkg::addr_word_t data_word;
    addr_map_pkg::region_t    pc_region;
    addr_map_pkg::region_t    data_region;

    function automatic addr_map_pkg::region_t decode_region(input addr_map_pkg::addr_word_t a);
        addr_map_pkg::region_t r;
        if (a.raw <= `DRAM_LAST)
            r = addr_map_pkg::DRAM;
        else if (a.io.page != `IO_PAGE)
            r = addr_map_pkg::UNMAPPED;
        else if (a.io.offset < `LED_COUNT)
            r = addr_map_pkg::LED;
        else if (a.io.offset == `UART_STATUS_OFS)
            r = addr_map_pkg::UART_STATUS;
        else if (a.io.offset == `UART_DATA_OFS)
            r = addr_map_pkg::UART_DATA;
        else
            r = addr_map_pkg::UNMAPPED;
        return r;
    endfunction

    function automatic logic [`DRAM_ADDR_WIDTH-1:0] to_dram_addr(input logic [`WORD_WIDTH-1:0] w);
        return {{(`DRAM_ADDR_WIDTH-`WORD_WIDTH){1'b0}}, w};
    endfunction

    assign pc_word.raw   = pc;
    assign data_word.raw = data_addr;
    assign pc_region     = decode_region(pc_word);
    assign data_region   = decode_region(data_word);
    assign fetch_addr    = (pc_region == addr_map_pkg::DRAM) ? pc : '0; // io fetches read word 0.

    always_comb begin
        case (data_region)
            addr_map_pkg::LED:
                io_rdata = {{(`WORD_WIDTH-1){1'b0}}, led[data_word.io.offset]};
            addr_map_pkg::UART_STATUS:
                io_rdata = {{(`WORD_WIDTH-1){1'b0}}, !fifo_full};
            default:
                io_rdata = '0;
        endcase
    end

    // instr and read_data only change together with step_done.
    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= ST_IDLE;
            last_valid <= 1'b0;
            dram_req   <= 1'b0;
            fifo_push  <= 1'b0;
            step_done  <= 1'b0;
            led        <= '0;
            instr      <= `NOP_INSTR;
            read_data  <= '0;
        end else begin
            fifo_push <= 1'b0;
            step_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cpu_ready && (!last_valid || pc != last_pc)) begin
                        last_pc    <= pc;
                        last_valid <= 1'b1;
                        dram_req   <= 1'b1;
                        dram_op    <= periph_pkg::READ;
                        dram_addr  <= to_dram_addr(fetch_addr);
                        state      <= ST_FETCH_REQ;
                    end
                end
                ST_FETCH_REQ: begin
                    if (dram_ack) begin
                        instr_buf <= dram_rdata;
                        dram_req  <= 1'b0;
                        state     <= ST_FETCH_REL;
                    end
                end
                ST_FETCH_REL: begin
                    if (!dram_ack)
                        state <= ST_DATA_DEC;
                end
                ST_DATA_DEC: begin
                    if (data_region == addr_map_pkg::DRAM) begin
                        dram_req   <= 1'b1;
                        dram_op    <= write_en ? periph_pkg::WRITE : periph_pkg::READ;
                        dram_addr  <= to_dram_addr(data_addr);
                        dram_wdata <= data_in;
                        state      <= ST_DATA_REQ;
                    end else if (!(write_en && data_region == addr_map_pkg::UART_DATA
                                   && fifo_full)) begin
                        if (write_en && data_region == addr_map_pkg::LED)
                            led[data_word.io.offset] <= data_in[0];
                        if (write_en && data_region == addr_map_pkg::UART_DATA) begin
                            fifo_push <= 1'b1;
                            fifo_byte <= data_in[7:0];
                        end
                        read_data <= write_en ? '0 : io_rdata; // writes read back as zero.
                        instr     <= instr_buf;
                        step_done <= 1'b1;
                        state     <= ST_DONE;
                    end
                end
                ST_DATA_REQ: begin
                    if (dram_ack) begin
                        data_buf <= (dram_op == periph_pkg::READ) ? dram_rdata : '0;
                        dram_req <= 1'b0;
                        state    <= ST_DATA_REL;
                    end
                end
                ST_DATA_REL: begin
                    if (!dram_ack) begin
                        read_data <= data_buf;
                        instr     <= instr_buf;
                        step_done <= 1'b1;
                        state     <= ST_DONE;
                    end
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
            if (!cpu_ready)
                last_valid <= 1'b0; // any pc starts a step once ready returns.
        end
    end

    a_req_after_ack: assert property (@(posedge clk) disable iff (!rst)
        $rose(dram_req) |-> !dram_ack)
        else $error("dram request raised while dram_ack still high");

    a_push_not_full: assert property (@(posedge clk) disable iff (!rst)
        fifo_push |-> !fifo_full)
        else $error("uart fifo push while fifo full");

endmodule

`default_nettype wire

// File: mem_subsys.f
+incdir+.
addr_map_pkg.sv
periph_pkg.sv
mem_map.sv
dram_ctrl.sv
uart_tx_fifo.sv
uart_tx.sv
mem_subsys.sv
tb_mem_subsys.sv

// File: mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_subsys (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [`WORD_WIDTH-1:0] pc,
    input  wire logic                   cpu_ready,
    input  wire logic [`WORD_WIDTH-1:0] data_addr,
    input  wire logic [`WORD_WIDTH-1:0] data_in,
    input  wire logic                   write_en,
    output logic [`WORD_WIDTH-1:0]      instr,
    output logic [`WORD_WIDTH-1:0]      read_data,
    output logic                        step_done,
    output logic [`LED_COUNT-1:0]       led,
    output logic                        uart_txd
);

    // sequencer to dram controller.
    logic                        dram_req;
    periph_pkg::dram_op_t        dram_op;
    logic [`DRAM_ADDR_WIDTH-1:0] dram_addr;
    logic [`WORD_WIDTH-1:0]      dram_wdata;
    logic                        dram_ack;
    logic [`WORD_WIDTH-1:0]      dram_rdata;

    // sequencer to fifo.
    logic                        fifo_push;
    logic [7:0]                  fifo_byte;
    logic                        fifo_full;

    // fifo to serializer.
    logic                        tx_req;
    logic [7:0]                  tx_byte;
    logic                        tx_ack;

    mem_map u_mem_map (.*);

    dram_ctrl u_dram_ctrl (.*);

    uart_tx_fifo u_uart_tx_fifo (.*);

    uart_tx u_uart_tx (.*);

endmodule

`default_nettype wire

// File: mem_subsys_defines.svh
`ifndef MEM_SUBSYS_DEFINES_SVH
`define MEM_SUBSYS_DEFINES_SVH

// word and address widths
`define WORD_WIDTH          16
`define DRAM_ADDR_WIDTH     25

// address map
`define DRAM_LAST           16'hF7FF
`define IO_PAGE             12'hF80
`define IO_OFS_WIDTH        4
`define LED_COUNT           10
`define UART_STATUS_OFS     4'hA
`define UART_DATA_OFS       4'hB

// behavioral dram timing, in clock cycles
`define DRAM_LATENCY        3
`define DRAM_REFRESH_PERIOD 64
`define DRAM_REFRESH_CYCLES 5

// uart transmit path
`define UART_FIFO_DEPTH     4
`define UART_CLKS_PER_BIT   4

`define NOP_INSTR           16'hF000

`endif

// File: periph_pkg.sv
`default_nettype none

package periph_pkg;

    typedef enum logic {
        READ,
        WRITE
    } dram_op_t;

    // 8n1 frame phases.
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f mem_subsys.f --top-module tb_mem_subsys -o sim_mem_subsys \
    && ./obj_dir/sim_mem_subsys > sim.log 2>&1 \
    || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// File: tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module tb_mem_subsys;

    localparam int N_RANDOM     = 150;
    localparam int STEP_COUNT   = 9 + 30 + 9 + 8 + N_RANDOM;
    localparam int BYTE_COUNT   = 2 * `UART_FIFO_DEPTH + N_RANDOM;
    localparam int STEP_WORST   = 2 * (`DRAM_LATENCY + `DRAM_REFRESH_CYCLES) + 8;
    localparam int FRAME_CYCLES = 10 * `UART_CLKS_PER_BIT;
    localparam int CYCLE_LIMIT  = 2 * (STEP_COUNT * STEP_WORST + BYTE_COUNT * FRAME_CYCLES);

    logic                   clk;
    logic                   rst;
    logic [`WORD_WIDTH-1:0] pc;
    logic                   cpu_ready;
    logic [`WORD_WIDTH-1:0] data_addr;
    logic [`WORD_WIDTH-1:0] data_in;
    logic                   write_en;
    logic [`WORD_WIDTH-1:0] instr;
    logic [`WORD_WIDTH-1:0] read_data;
    logic                   step_done;
    logic [`LED_COUNT-1:0]  led;
    logic                   uart_txd;

    logic [`WORD_WIDTH-1:0] mem_model [logic [`WORD_WIDTH-1:0]]; // absent words read as 0.
    logic [`LED_COUNT-1:0]  led_model;
    logic [7:0]             tx_q [$];
    logic [7:0]             rx_byte;
    logic [7:0]             rx_exp;
    logic [31:0]            rng_state;
    logic [31:0]            r;
    logic [31:0]            w;
    logic [15:0]            addr;
    logic [15:0]            rpc;
    logic [15:0]            prev_pc;
    logic [15:0]            pc_ctr;
    int                     bytes_pushed;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     async_fails;
    int                     pass_mark;
    int                     fail_mark;
    int                     cycles;

    mem_subsys DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] rand_word();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // address map as the bus unit sees it.
    function automatic addr_map_pkg::region_t region_of(input logic [15:0] a);
        addr_map_pkg::addr_word_t aw;
        aw.raw = a;
        if (aw.raw <= `DRAM_LAST)
            return addr_map_pkg::DRAM;
        if (aw.io.page != `IO_PAGE)
            return addr_map_pkg::UNMAPPED;
        case (aw.io.offset)
            `UART_STATUS_OFS: return addr_map_pkg::UART_STATUS;
            `UART_DATA_OFS:   return addr_map_pkg::UART_DATA;
            default:          return (aw.io.offset < `LED_COUNT) ? addr_map_pkg::LED
                                                                 : addr_map_pkg::UNMAPPED;
        endcase
    endfunction

    function automatic logic [15:0] model_read(input logic [15:0] a);
        return mem_model.exists(a) ? mem_model[a] : 16'h0000;
    endfunction

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp)
            pass_cnt++;
        else begin
            fail_cnt++;
            $display("[ERROR] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s finished: %0d checks passed, %0d failed", name, pass_cnt - pass_mark,
                 fail_cnt + async_fails - fail_mark);
        pass_mark = pass_cnt;
        fail_mark = fail_cnt + async_fails;
    endtask

    task automatic do_step(input logic [15:0] step_pc, input logic [15:0] a,
                           input logic [15:0] wdata, input logic wr, input logic drop);
        addr_map_pkg::region_t reg_sel;
        logic [15:0]           exp_instr;
        logic [15:0]           exp_rdata;
        int                    ofs;
        int                    backlog;
        bit                    known;
        reg_sel   = region_of(a);
        ofs       = a[3:0];
        backlog   = tx_q.size();
        known     = 1'b1;
        exp_rdata = 16'h0000;
        exp_instr = model_read((step_pc <= `DRAM_LAST) ? step_pc : 16'h0000); // before the write.
        if (!wr && reg_sel == addr_map_pkg::DRAM)
            exp_rdata = model_read(a);
        if (!wr && reg_sel == addr_map_pkg::LED)
            exp_rdata = {15'd0, led_model[ofs]};
        if (wr && reg_sel == addr_map_pkg::UART_DATA) begin
            tx_q.push_back(wdata[7:0]);
            bytes_pushed++;
        end
        if (drop || step_pc == prev_pc) begin
            @(posedge clk);
            cpu_ready <= 1'b0;
        end
        @(posedge clk);
        pc        <= step_pc;
        data_addr <= a;
        data_in   <= wdata;
        write_en  <= wr;
        cpu_ready <= 1'b1;
        do @(negedge clk); while (step_done !== 1'b1);
        if (!wr && reg_sel == addr_map_pkg::UART_STATUS) begin
            // unsent bytes sit in the fifo or in the serializer.
            exp_rdata = (backlog < `UART_FIFO_DEPTH) ? 16'h0001 : 16'h0000;
            known     = (backlog < `UART_FIFO_DEPTH) || (tx_q.size() > `UART_FIFO_DEPTH);
        end
        if (wr && reg_sel == addr_map_pkg::DRAM)
            mem_model[a] = wdata;
        if (wr && reg_sel == addr_map_pkg::LED)
            led_model[ofs] = wdata[0];
        check_word("instr", exp_instr, instr);
        if (known)
            check_word("read_data", exp_rdata, read_data);
        check_word("led", {6'd0, led_model}, {6'd0, led});
        prev_pc = step_pc;
    endtask

    task automatic seq_step(input logic [15:0] a, input logic [15:0] wdata, input logic wr);
        do_step(pc_ctr, a, wdata, wr, 1'b0);
        pc_ctr++;
    endtask

    task automatic wait_drain();
        while (tx_q.size() != 0)
            @(negedge clk);
        repeat (`UART_CLKS_PER_BIT) @(negedge clk);
    endtask

    // serial decoder sampling each bit near its middle.
    always begin
        @(negedge clk);
        if (rst && uart_txd === 1'b0) begin
            repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
            assert (uart_txd === 1'b0)
            else begin
                async_fails++;
                $display("uart start bit ended before half a bit time");
            end
            for (int i = 0; i < 8; i++) begin
                repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                rx_byte[i] = uart_txd;
            end
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            assert (uart_txd === 1'b1)
            else begin
                async_fails++;
                $display("uart stop bit missing after byte %h", rx_byte);
            end
            if (tx_q.size() == 0) begin
                async_fails++;
                $display("uart sent byte %h that was never written", rx_byte);
            end else begin
                rx_exp = tx_q.pop_front();
                assert (rx_byte === rx_exp)
                else begin
                    async_fails++;
                    $display("[ERROR] uart_txd byte expected %h got %h", rx_exp, rx_byte);
                end
            end
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        step_done |=> !step_done)
        else begin
            async_fails++;
            $display("step_done stayed high for two cycles");
        end

    a_led_at_done: assert property (@(posedge clk) disable iff (!rst)
        !$stable(led) |-> step_done)
        else begin
            async_fails++;
            $display("led changed outside the end of a step");
        end

    a_line_idle: assert property (@(posedge clk) disable iff (!rst)
        bytes_pushed == 0 |-> uart_txd)
        else begin
            async_fails++;
            $display("uart_txd left idle before any uart write");
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        pc           = '0;
        cpu_ready    = 1'b0;
        data_addr    = '0;
        data_in      = '0;
        write_en     = 1'b0;
        led_model    = '0;
        rng_state    = 32'd1106;
        prev_pc      = 16'hFFFF;
        pc_ctr       = 16'h0040;
        bytes_pushed = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        async_fails  = 0;
        pass_mark    = 0;
        fail_mark    = 0;
        cycles       = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;

        repeat (2) @(negedge clk);
        check_word("instr", `NOP_INSTR, instr);
        check_word("led", 16'h0000, {6'd0, led});
        check_word("uart_txd", 16'h0001, {15'd0, uart_txd});
        check_word("step_done", 16'h0000, {15'd0, step_done});
        end_test("reset values");

        seq_step(16'h0100, 16'h1234, 1'b1);
        seq_step(`DRAM_LAST, 16'hBEEF, 1'b1);
        seq_step(16'h0000, 16'h5A5A, 1'b1);
        seq_step(16'h0100, 16'h0000, 1'b0);
        seq_step(`DRAM_LAST, 16'h0000, 1'b0);
        seq_step(16'h0000, 16'h0000, 1'b0);
        seq_step(16'h0200, 16'h0000, 1'b0); // never written.
        do_step(16'h0100, 16'h0000, 16'h0000, 1'b0, 1'b0);
        do_step(16'hF900, 16'h0100, 16'h0000, 1'b0, 1'b0); // fetch above dram reads word 0.
        end_test("dram round trip");

        for (int i = 0; i < `LED_COUNT; i++) begin
            w = rand_word();
            seq_step({`IO_PAGE, 4'(i)}, w[15:0], 1'b1);
            seq_step({`IO_PAGE, 4'(i)}, 16'h0000, 1'b0);
        end
        for (int i = 0; i < `LED_COUNT; i++) begin
            w = rand_word();
            seq_step({`IO_PAGE, 4'(i)}, {w[15:1], ~led_model[i]}, 1'b1);
        end
        end_test("led bank");

        for (int i = 0; i < 2 * `UART_FIFO_DEPTH; i++) begin
            w = rand_word();
            seq_step({`IO_PAGE, `UART_DATA_OFS}, w[15:0], 1'b1);
        end
        wait_drain();
        seq_step({`IO_PAGE, `UART_STATUS_OFS}, 16'h0000, 1'b0);
        end_test("uart burst");

        seq_step({`IO_PAGE, `UART_DATA_OFS}, 16'h0000, 1'b0);
        seq_step({`IO_PAGE, 4'hC}, 16'h0000, 1'b0);
        seq_step({`IO_PAGE, 4'hF}, 16'h0000, 1'b0);
        seq_step(16'hF900, 16'h0000, 1'b0);
        seq_step(16'hFFFF, 16'h0000, 1'b0);
        seq_step({`IO_PAGE, 4'hD}, 16'hFFFF, 1'b1);
        seq_step(16'hF910, 16'hFFFF, 1'b1);
        seq_step({`IO_PAGE, `UART_STATUS_OFS}, 16'h00FF, 1'b1);
        end_test("unmapped and register reads");

        for (int n = 0; n < N_RANDOM; n++) begin
            r = rand_word();
            w = rand_word();
            case (r[2:0])
                3'd0, 3'd1, 3'd2: addr = r[6] ? {8'h00, r[23:16]} : 16'(r[31:16] % 32'hF800);
                3'd3, 3'd4:       addr = {`IO_PAGE, 4'(r[19:16] % `LED_COUNT)};
                3'd5:             addr = {`IO_PAGE, `UART_DATA_OFS};
                3'd6:             addr = {`IO_PAGE, `UART_STATUS_OFS};
                default:          addr = r[6] ? {`IO_PAGE, 2'b11, r[17:16]}
                                              : (16'hF900 | {8'h00, r[23:16]});
            endcase
            case (r[9:8])
                2'd0:    rpc = prev_pc; // same pc again after a ready drop.
                2'd1:    rpc = 16'hF800 | {8'h00, r[31:24]};
                default: rpc = {8'h00, r[31:24]};
            endcase
            do_step(rpc, addr, w[15:0], r[3] || (r[2:0] == 3'd5 && r[7]), r[5:4] == 2'b00);
        end
        wait_drain();
        end_test("random mix");

        $display("total: %0d checks passed, %0d failed", pass_cnt, fail_cnt + async_fails);
        if (fail_cnt + async_fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module uart_tx (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       tx_req,
    input  wire logic [7:0] tx_byte,
    output logic            tx_ack,
    output logic            uart_txd
);

    localparam int CLK_W = $clog2(`UART_CLKS_PER_BIT);

    periph_pkg::tx_state_t state;
    logic [CLK_W-1:0]      clk_cnt;
    logic [2:0]            bit_idx;
    logic [7:0]            shift;
    logic                  bit_end;

    assign bit_end = (clk_cnt == CLK_W'(`UART_CLKS_PER_BIT - 1));

    // uart_txd is registered, so each bit shows one cycle after its state.
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= periph_pkg::IDLE;
            tx_ack   <= 1'b0;
            uart_txd <= 1'b1;
            clk_cnt  <= '0;
            bit_idx  <= '0;
        end else begin
            if (tx_ack && !tx_req)
                tx_ack <= 1'b0;
            if (state != periph_pkg::IDLE)
                clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                periph_pkg::IDLE: begin
                    uart_txd <= 1'b1;
                    clk_cnt  <= '0;
                    if (tx_req && !tx_ack) begin
                        shift  <= tx_byte;
                        tx_ack <= 1'b1;
                        state  <= periph_pkg::START;
                    end
                end
                periph_pkg::START: begin
                    uart_txd <= 1'b0;
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= periph_pkg::DATA;
                    end
                end
                periph_pkg::DATA: begin
                    uart_txd <= shift[0]; // lsb first.
                    if (bit_end) begin
                        shift <= shift >> 1;
                        if (bit_idx == 3'd7)
                            state <= periph_pkg::STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                end
                periph_pkg::STOP: begin
                    uart_txd <= 1'b1;
                    if (bit_end)
                        state <= periph_pkg::IDLE;
                end
                default: state <= periph_pkg::IDLE;
            endcase
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(tx_ack) |-> tx_req)
        else $error("tx_ack raised without tx_req");

endmodule

`default_nettype wire

// File: uart_tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module uart_tx_fifo (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       fifo_push,
    input  wire logic [7:0] fifo_byte,
    input  wire logic       tx_ack,
    output logic            fifo_full,
    output logic            tx_req,
    output logic [7:0]      tx_byte
);

    localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`UART_FIFO_DEPTH + 1);

    logic [7:0]       entries [0:`UART_FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`UART_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop       = tx_req && tx_ack; // first cycle of ack high.
    assign fifo_full = (count == CNT_W'(`UART_FIFO_DEPTH));
    assign tx_byte   = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (fifo_push)
            entries[wr_ptr] <= fifo_byte;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            tx_req <= 1'b0;
        end else begin
            if (fifo_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (fifo_push && !pop)
                count <= count + 1'b1;
            else if (pop && !fifo_push)
                count <= count - 1'b1;
            if (pop)
                tx_req <= 1'b0;
            else if (!tx_req && !tx_ack && (count != '0 || fifo_push))
                tx_req <= 1'b1; // next request waits for ack low.
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        count <= CNT_W'(`UART_FIFO_DEPTH))
        else $error("uart fifo overflow");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst)
        tx_req |-> count != '0)
        else $error("uart fifo request with no entry");

endmodule

`default_nettype wire
